// ==== axi_lite_pkg.sv ====
// AXI4-Lite read channel types
package axi_lite_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [2:0]           prot_t;

  // Response codes as on the bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // AR payload, 35 bits
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  // R payload, 34 bits
  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

endpackage

// ==== mux_cfg_pkg.sv ====
// Sizing of the read multiplexer
package mux_cfg_pkg;

  // Subordinate ports feeding the one manager port
  localparam int unsigned NumSbrPorts = 4;

  // Reads in flight toward the manager
  localparam int unsigned MaxTrans = 4;

  // Port index
  localparam int unsigned SelWidth = $clog2(NumSbrPorts);
  typedef logic [SelWidth-1:0] select_t;

  // Route FIFO pointers
  localparam int unsigned FifoPtrWidth = $clog2(MaxTrans);

endpackage

// ==== sbr_rd_if.sv ====
`timescale 1ns/100ps

// One port's read channels between its holding registers and the mux core
interface sbr_rd_if;

  // AR channel toward the arbiter
  logic                   ar_valid;
  logic                   ar_ready;
  axi_lite_pkg::ar_chan_t ar;

  // R channel back from the router
  logic                   r_valid;
  logic                   r_ready;
  axi_lite_pkg::r_chan_t  r;

  // Port side of the link
  modport port_mp (
    output ar_valid, ar, r_ready,
    input  ar_ready, r_valid, r
  );

  // Core side, mirror of the port side
  // Arbiter owns ar_ready, router owns r_valid and r
  modport mux_mp (
    input  ar_valid, ar, r_ready,
    output ar_ready, r_valid, r
  );

endinterface

// ==== sbr_read_port.sv ====
`timescale 1ns/100ps

// One-entry AR and R holding registers for a subordinate port
module sbr_read_port (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   ar_valid_i,
  input  axi_lite_pkg::ar_chan_t ar_i,
  output logic                   ar_ready_o,
  output logic                   r_valid_o,
  output axi_lite_pkg::r_chan_t  r_o,
  input  logic                   r_ready_i,
  sbr_rd_if.port_mp              bus
);
  import axi_lite_pkg::*;

  logic     ar_full_q;
  ar_chan_t ar_q;
  logic     ar_load;
  logic     ar_drain;

  logic     r_full_q;
  r_chan_t  r_q;
  logic     r_load;
  logic     r_drain;

  // ------------------------------
  // AR holding register
  // ------------------------------
  // Arbiter takes the entry this cycle
  assign ar_drain   = ar_full_q & bus.ar_ready;
  // Empty or emptying, so full rate
  assign ar_ready_o = ~ar_full_q | ar_drain;
  assign ar_load    = ar_valid_i & ar_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_full_q <= 1'b0;
    end else if (ar_load) begin
      ar_full_q <= 1'b1;
    end else if (ar_drain) begin
      ar_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_load) begin
      ar_q <= ar_i;
    end
  end

  assign bus.ar_valid = ar_full_q;
  assign bus.ar       = ar_q;

  // ------------------------------
  // R holding register
  // ------------------------------
  // Room when empty or read out this cycle
  assign bus.r_ready = ~r_full_q | r_ready_i;
  assign r_load      = bus.r_valid & bus.r_ready;
  assign r_drain     = r_full_q & r_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_full_q <= 1'b0;
    end else if (r_load) begin
      r_full_q <= 1'b1;
    end else if (r_drain) begin
      r_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_load) begin
      r_q <= bus.r;
    end
  end

  assign r_valid_o = r_full_q;
  assign r_o       = r_q;

endmodule

// ==== rd_arbiter.sv ====
`timescale 1ns/100ps

// Round-robin AR arbiter with lock-in, stalled while the route FIFO is full
module rd_arbiter (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  sbr_rd_if.mux_mp               ports [mux_cfg_pkg::NumSbrPorts-1:0],
  input  logic                   fifo_full_i,
  output logic                   push_o,
  output mux_cfg_pkg::select_t   push_sel_o,
  output logic                   mgr_ar_valid_o,
  output axi_lite_pkg::ar_chan_t mgr_ar_o,
  input  logic                   mgr_ar_ready_i
);
  import axi_lite_pkg::*;
  import mux_cfg_pkg::*;

  // Lock state of the grant
  typedef enum logic {
    ST_IDLE,
    ST_LOCKED
  } arb_state_e;

  logic     [NumSbrPorts-1:0] req;
  ar_chan_t [NumSbrPorts-1:0] ar_chans;

  arb_state_e state_q, state_d;
  select_t    rr_q, rr_d;
  select_t    lock_sel_q, lock_sel_d;
  select_t    cand_sel;
  select_t    arb_sel;
  logic       arb_valid;
  logic       ar_xfer;

  // Unpack requests, grant only the forwarded port
  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_ports
    assign req[i]           = ports[i].ar_valid;
    assign ar_chans[i]      = ports[i].ar;
    assign ports[i].ar_ready = ar_xfer & (arb_sel == select_t'(i));
  end

  // ------------------------------
  // Selection
  // ------------------------------
  always_comb begin
    arb_valid = 1'b0;
    arb_sel   = rr_q;
    cand_sel  = rr_q;
    if (state_q == ST_LOCKED) begin
      // Held port keeps its valid up until accepted
      arb_sel   = lock_sel_q;
      arb_valid = req[lock_sel_q];
    end else begin
      // First requester at or after the pointer
      for (int unsigned k = 0; k < NumSbrPorts; k++) begin
        cand_sel = select_t'(rr_q + k);
        if (!arb_valid && req[cand_sel]) begin
          arb_valid = 1'b1;
          arb_sel   = cand_sel;
        end
      end
    end
  end

  // No new read without a free route slot
  assign mgr_ar_valid_o = arb_valid & ~fifo_full_i;
  assign mgr_ar_o       = ar_chans[arb_sel];
  assign ar_xfer        = mgr_ar_valid_o & mgr_ar_ready_i;

  // Winner index goes into the route FIFO
  assign push_o     = ar_xfer;
  assign push_sel_o = arb_sel;

  // ------------------------------
  // Lock and pointer update
  // ------------------------------
  always_comb begin
    state_d    = state_q;
    rr_d       = rr_q;
    lock_sel_d = lock_sel_q;
    if (ar_xfer) begin
      state_d = ST_IDLE;
      // Winner drops to lowest priority
      rr_d    = select_t'(arb_sel + 1'b1);
    end else if (mgr_ar_valid_o) begin
      state_d    = ST_LOCKED;
      lock_sel_d = arb_sel;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ST_IDLE;
      rr_q       <= '0;
      lock_sel_q <= '0;
    end else begin
      state_q    <= state_d;
      rr_q       <= rr_d;
      lock_sel_q <= lock_sel_d;
    end
  end

endmodule

// ==== route_fifo.sv ====
`timescale 1ns/100ps

// Order of outstanding reads, one port index per read
module route_fifo (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 push_i,
  input  mux_cfg_pkg::select_t sel_i,
  output logic                 full_o,
  input  logic                 pop_i,
  output mux_cfg_pkg::select_t sel_o,
  output logic                 empty_o
);
  import mux_cfg_pkg::*;

  select_t                 mem [MaxTrans];
  logic [FifoPtrWidth-1:0] wr_ptr_q;
  logic [FifoPtrWidth-1:0] rd_ptr_q;
  // One bit wider than the pointers to hold MaxTrans
  logic [FifoPtrWidth:0]   count_q;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (count_q == (FifoPtrWidth + 1)'(MaxTrans));
  assign empty_o = (count_q == '0);

  // Overflow and underflow are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Registered head, no fall-through
  assign sel_o = mem[rd_ptr_q];

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= sel_i;
    end
  end

endmodule

// ==== r_router.sv ====
`timescale 1ns/100ps

// In-order R return, steered by the route FIFO head
module r_router (
  sbr_rd_if.mux_mp               ports [mux_cfg_pkg::NumSbrPorts-1:0],
  input  logic                   fifo_empty_i,
  input  mux_cfg_pkg::select_t   head_sel_i,
  output logic                   pop_o,
  input  logic                   mgr_r_valid_i,
  input  axi_lite_pkg::r_chan_t  mgr_r_i,
  output logic                   mgr_r_ready_o
);
  import mux_cfg_pkg::*;

  logic [NumSbrPorts-1:0] port_ready;

  // ------------------------------
  // Response fan-out
  // ------------------------------
  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_ports
    // Payload to all, valid only to the head port
    assign ports[i].r       = mgr_r_i;
    assign ports[i].r_valid = mgr_r_valid_i & ~fifo_empty_i &
                              (head_sel_i == select_t'(i));
    assign port_ready[i]    = ports[i].r_ready;
  end

  // Stalls behind the head port, keeps the order
  assign mgr_r_ready_o = ~fifo_empty_i & port_ready[head_sel_i];

  // Retire the route entry on delivery
  assign pop_o = mgr_r_valid_i & mgr_r_ready_o;

endmodule

// ==== lite_rd_mux.sv ====
`timescale 1ns/100ps

// AXI4-Lite read mux, four subordinate ports onto one manager port
module lite_rd_mux (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  // Subordinate ports
  input  logic                   [mux_cfg_pkg::NumSbrPorts-1:0] sbr_ar_valid_i,
  input  axi_lite_pkg::ar_chan_t [mux_cfg_pkg::NumSbrPorts-1:0] sbr_ar_i,
  output logic                   [mux_cfg_pkg::NumSbrPorts-1:0] sbr_ar_ready_o,
  output logic                   [mux_cfg_pkg::NumSbrPorts-1:0] sbr_r_valid_o,
  output axi_lite_pkg::r_chan_t  [mux_cfg_pkg::NumSbrPorts-1:0] sbr_r_o,
  input  logic                   [mux_cfg_pkg::NumSbrPorts-1:0] sbr_r_ready_i,
  // Manager port
  output logic                                                 mgr_ar_valid_o,
  output axi_lite_pkg::ar_chan_t                               mgr_ar_o,
  input  logic                                                 mgr_ar_ready_i,
  input  logic                                                 mgr_r_valid_i,
  input  axi_lite_pkg::r_chan_t                                mgr_r_i,
  output logic                                                 mgr_r_ready_o
);
  import mux_cfg_pkg::*;

  // Links between port registers and core
  sbr_rd_if port_bus [NumSbrPorts-1:0] ();

  // Route FIFO handshake
  logic    fifo_push;
  logic    fifo_pop;
  logic    fifo_full;
  logic    fifo_empty;
  select_t push_sel;
  select_t head_sel;

  // ------------------------------
  // Per-port holding registers
  // ------------------------------
  for (genvar i = 0; i < NumSbrPorts; i++) begin : gen_ports
    sbr_read_port i_port (
      .clk_i      ( clk_i             ),
      .arst_n_i   ( arst_n_i          ),
      .ar_valid_i ( sbr_ar_valid_i[i] ),
      .ar_i       ( sbr_ar_i[i]       ),
      .ar_ready_o ( sbr_ar_ready_o[i] ),
      .r_valid_o  ( sbr_r_valid_o[i]  ),
      .r_o        ( sbr_r_o[i]        ),
      .r_ready_i  ( sbr_r_ready_i[i]  ),
      .bus        ( port_bus[i]       )
    );
  end

  // ------------------------------
  // Shared core
  // ------------------------------
  // AR side drains the port registers
  rd_arbiter i_arbiter (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .ports          ( port_bus       ),
    .fifo_full_i    ( fifo_full      ),
    .push_o         ( fifo_push      ),
    .push_sel_o     ( push_sel       ),
    .mgr_ar_valid_o ( mgr_ar_valid_o ),
    .mgr_ar_o       ( mgr_ar_o       ),
    .mgr_ar_ready_i ( mgr_ar_ready_i )
  );

  route_fifo i_route_fifo (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .push_i   ( fifo_push  ),
    .sel_i    ( push_sel   ),
    .full_o   ( fifo_full  ),
    .pop_i    ( fifo_pop   ),
    .sel_o    ( head_sel   ),
    .empty_o  ( fifo_empty )
  );

  // R side fills the port registers
  r_router i_r_router (
    .ports         ( port_bus      ),
    .fifo_empty_i  ( fifo_empty    ),
    .head_sel_i    ( head_sel      ),
    .pop_o         ( fifo_pop      ),
    .mgr_r_valid_i ( mgr_r_valid_i ),
    .mgr_r_i       ( mgr_r_i       ),
    .mgr_r_ready_o ( mgr_r_ready_o )
  );

endmodule

// ==== tb_lite_rd_mux.sv ====
`timescale 1ns/100ps

module tb_lite_rd_mux;
  import axi_lite_pkg::*;
  import mux_cfg_pkg::*;

  // Run budget per trace line, plus setup margin
  localparam int unsigned TimeoutPerEntry = 64;
  localparam int unsigned TimeoutBase     = 100;
  // Responder data rule
  localparam data_t       RespXor         = 32'hA5A50000;
  // Manager R withheld this long after the round-robin phase
  localparam int          HoldCycles      = 30;

  typedef enum int {
    M_IDLE,
    M_RR_LOAD,
    M_RR_GRANT,
    M_RUN
  } tb_mode_e;

  logic                       clk_i;
  logic                       arst_n_i;
  logic     [NumSbrPorts-1:0] sbr_ar_valid_i = '0;
  ar_chan_t [NumSbrPorts-1:0] sbr_ar_i       = '0;
  logic     [NumSbrPorts-1:0] sbr_ar_ready_o;
  logic     [NumSbrPorts-1:0] sbr_r_valid_o;
  r_chan_t  [NumSbrPorts-1:0] sbr_r_o;
  logic     [NumSbrPorts-1:0] sbr_r_ready_i  = '0;
  logic                       mgr_ar_valid_o;
  ar_chan_t                   mgr_ar_o;
  logic                       mgr_ar_ready_i = 1'b0;
  logic                       mgr_r_valid_i  = 1'b0;
  r_chan_t                    mgr_r_i        = '0;
  logic                       mgr_r_ready_o;

  // Per-port stimulus, ARs waiting in the DUT, expected responses
  ar_chan_t stim_q    [NumSbrPorts][$];
  ar_chan_t pend_ar_q [NumSbrPorts][$];
  r_chan_t  exp_r_q   [NumSbrPorts][$];
  // Reads accepted by the manager model, answered in order
  ar_chan_t rsp_q [$];
  // Port R payload seen while stalled
  r_chan_t  held_r [NumSbrPorts];

  logic [NumSbrPorts-1:0] held     = '0;
  logic [NumSbrPorts-1:0] loaded   = '0;
  logic [NumSbrPorts-1:0] accepted = '0;
  logic                   r_xfer   = 1'b0;
  tb_mode_e               mode     = M_IDLE;
  integer                 seed     = 32'h67ea;
  int                     total     = 0;
  int                     checked   = 0;
  int                     rr_grants = 0;
  int                     hold_cnt  = 0;
  int                     hit       = 0;
  int unsigned            cycle_cnt      = 0;
  int unsigned            timeout_cycles = 0;

  lite_rd_mux dut0 (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .sbr_ar_valid_i ( sbr_ar_valid_i ),
    .sbr_ar_i       ( sbr_ar_i       ),
    .sbr_ar_ready_o ( sbr_ar_ready_o ),
    .sbr_r_valid_o  ( sbr_r_valid_o  ),
    .sbr_r_o        ( sbr_r_o        ),
    .sbr_r_ready_i  ( sbr_r_ready_i  ),
    .mgr_ar_valid_o ( mgr_ar_valid_o ),
    .mgr_ar_o       ( mgr_ar_o       ),
    .mgr_ar_ready_i ( mgr_ar_ready_i ),
    .mgr_r_valid_i  ( mgr_r_valid_i  ),
    .mgr_r_i        ( mgr_r_i        ),
    .mgr_r_ready_o  ( mgr_r_ready_o  )
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare_ar(input string name, input ar_chan_t got, input ar_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got addr %h prot %h expected addr %h prot %h",
                          name, got.addr, got.prot, exp.addr, exp.prot));
    end
  endtask

  task automatic compare_r(input string name, input r_chan_t got, input r_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got data %h resp %h expected data %h resp %h",
                          name, got.data, got.resp, exp.data, exp.resp));
    end
  endtask

  task automatic compare_sel(input string name, input select_t got, input select_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  // True with the given percentage
  function automatic logic chance(input int unsigned pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 32'd100) < pct;
  endfunction

  // Manager model answer for one read
  function automatic r_chan_t respond(input ar_chan_t ar);
    r_chan_t r;
    r.data = ar.addr ^ RespXor;
    r.resp = (ar.addr[31:28] == 4'hF) ? SLVERR : OKAY;
    return r;
  endfunction

  task automatic load_trace();
    int          fd;
    int          n;
    int          port;
    string       line;
    logic [31:0] addr;
    logic [2:0]  prot;
    logic [31:0] data;
    logic [1:0]  resp;
    ar_chan_t    ar;
    r_chan_t     r;
    fd = $fopen("rd_trace.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open rd_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Comment and blank lines give fewer fields
      n = $sscanf(line, "%d %h %h %h %h", port, addr, prot, data, resp);
      if (n == 5) begin
        if (port < 0 || port >= int'(NumSbrPorts)) begin
          abort_run($sformatf("trace line names port %0d, which does not exist", port));
        end
        ar.addr = addr;
        ar.prot = prot;
        r.data  = data;
        r.resp  = resp_e'(resp);
        stim_q[port].push_back(ar);
        exp_r_q[port].push_back(r);
        total++;
      end
    end
    $fclose(fd);
    for (int p = 0; p < NumSbrPorts; p++) begin
      if (stim_q[p].size() == 0) begin
        abort_run($sformatf("trace holds no read for port %0d", p));
      end
    end
  endtask

  // ------------------------------
  // Clock, reset, sequence
  // ------------------------------
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    arst_n_i = 1'b0;
    load_trace();
    timeout_cycles = TimeoutPerEntry * total + TimeoutBase;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    // Fill every AR register while the manager stalls
    mode = M_RR_LOAD;
    while (loaded != '1) @(negedge clk_i);
    // Manager ready held high, grants must go 0, 1, 2, 3
    mode = M_RR_GRANT;
    while (rr_grants < NumSbrPorts) @(negedge clk_i);
    mode = M_RUN;
    while (checked < total) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    if (rsp_q.size() != 0) begin
      $display("manager model still holds reads after the last response");
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      abort_run($sformatf("run did not finish within %0d cycles", timeout_cycles));
    end
  end

  // ------------------------------
  // Monitors and drivers
  // ------------------------------
  always @(posedge clk_i) begin
    if (arst_n_i && mode != M_IDLE) begin
      // ARs taken by the port registers
      for (int p = 0; p < NumSbrPorts; p++) begin
        accepted[p] = sbr_ar_valid_i[p] & sbr_ar_ready_o[p];
        if (accepted[p]) begin
          pend_ar_q[p].push_back(sbr_ar_i[p]);
          void'(stim_q[p].pop_front());
        end
      end
      // Manager AR must be the oldest waiting AR of some port
      if (mgr_ar_valid_o && mgr_ar_ready_i) begin
        hit = -1;
        for (int p = 0; p < NumSbrPorts; p++) begin
          if (hit < 0 && pend_ar_q[p].size() != 0 &&
              pend_ar_q[p][0].addr == mgr_ar_o.addr) begin
            hit = p;
          end
        end
        if (hit < 0) begin
          abort_run($sformatf("error: mgr_ar_o addr %h matches no waiting port AR",
                              mgr_ar_o.addr));
        end
        compare_ar("mgr_ar_o", mgr_ar_o, pend_ar_q[hit][0]);
        if (mode == M_RR_GRANT) begin
          compare_sel("grant port", select_t'(hit), select_t'(rr_grants));
          rr_grants++;
        end
        void'(pend_ar_q[hit].pop_front());
        rsp_q.push_back(mgr_ar_o);
      end
      r_xfer = mgr_r_valid_i & mgr_r_ready_o;
      if (r_xfer) begin
        void'(rsp_q.pop_front());
      end
      if (rsp_q.size() > MaxTrans) begin
        abort_run($sformatf("more than %0d reads outstanding at the manager", MaxTrans));
      end
      // Port responses, in order and stable under stall
      for (int p = 0; p < NumSbrPorts; p++) begin
        if (held[p]) begin
          if (!sbr_r_valid_o[p]) begin
            abort_run($sformatf("port %0d dropped r_valid before r_ready", p));
          end
          compare_r($sformatf("sbr_r_o[%0d] held", p), sbr_r_o[p], held_r[p]);
        end
        if (sbr_r_valid_o[p] && sbr_r_ready_i[p]) begin
          if (exp_r_q[p].size() == 0) begin
            abort_run($sformatf("port %0d got a response it never asked for", p));
          end
          compare_r($sformatf("sbr_r_o[%0d]", p), sbr_r_o[p], exp_r_q[p][0]);
          void'(exp_r_q[p].pop_front());
          checked++;
        end
        held[p]   = sbr_r_valid_o[p] & ~sbr_r_ready_i[p];
        held_r[p] = sbr_r_o[p];
      end

      // Port AR drivers
      for (int p = 0; p < NumSbrPorts; p++) begin
        if (mode == M_RR_LOAD) begin
          if (accepted[p]) begin
            loaded[p] = 1'b1;
          end
          if (!loaded[p] && stim_q[p].size() != 0) begin
            sbr_ar_valid_i[p] <= 1'b1;
            sbr_ar_i[p]       <= stim_q[p][0];
          end else begin
            sbr_ar_valid_i[p] <= 1'b0;
          end
        end else if (mode == M_RUN) begin
          // Valid holds until taken
          if (!sbr_ar_valid_i[p] || accepted[p]) begin
            if (stim_q[p].size() != 0 && chance(60)) begin
              sbr_ar_valid_i[p] <= 1'b1;
              sbr_ar_i[p]       <= stim_q[p][0];
            end else begin
              sbr_ar_valid_i[p] <= 1'b0;
            end
          end
        end else begin
          sbr_ar_valid_i[p] <= 1'b0;
        end
        sbr_r_ready_i[p] <= chance(65);
      end

      // Manager model
      if (mode == M_RR_GRANT) begin
        mgr_ar_ready_i <= 1'b1;
        hold_cnt       = HoldCycles;
      end else if (mode == M_RUN) begin
        mgr_ar_ready_i <= chance(70);
        if (hold_cnt != 0) begin
          hold_cnt--;
        end
      end else begin
        mgr_ar_ready_i <= 1'b0;
      end
      if (!mgr_r_valid_i || r_xfer) begin
        if (mode == M_RUN && hold_cnt == 0 && rsp_q.size() != 0 && chance(75)) begin
          mgr_r_valid_i <= 1'b1;
          mgr_r_i       <= respond(rsp_q[0]);
        end else begin
          mgr_r_valid_i <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== rd_trace.txt ====
# Read trace: one read per line, in issue order per port
# port  addr(hex)  prot(hex)  exp_data(hex)  exp_resp(hex, 0 OKAY, 2 SLVERR)
2 20003000 4 85A53000 0
0 00001000 0 A5A51000 0
3 30004000 2 95A54000 0
1 10002000 3 B5A52000 0
0 F0000010 1 55A50010 2
1 10002008 0 B5A52008 0
2 3C3C0F0F 1 99990F0F 0
3 5A5A5A5A 3 FFFF5A5A 0
1 FFFF0000 5 5A5A0000 2
0 00001004 2 A5A51004 0
3 0000FFFC 0 A5A5FFFC 0
2 F00D0004 2 55A80004 2
2 40000040 6 E5A50040 0
0 12345678 0 B7915678 0
3 FEED0100 1 5B480100 2
1 2000A000 7 85A5A000 0

// ==== flist.f ====
axi_lite_pkg.sv
mux_cfg_pkg.sv
sbr_rd_if.sv
sbr_read_port.sv
rd_arbiter.sv
route_fifo.sv
r_router.sv
lite_rd_mux.sv
tb_lite_rd_mux.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/100ps
TOP       := tb_lite_rd_mux
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
